//--- bench/apb_tb_input.hex
// Columns: op (1 = write) addr wdata strb expected_rdata expected_err, all hex
// Writes expect zero rdata, tag is the line index modulo 16
// Registers after reset
0 000 00000000 0 00000000 0
0 004 00000000 0 00000000 0
0 008 00000000 0 00000000 0
0 00C 00000000 0 00000000 0
0 010 00000000 0 00000000 0
0 01C 00000000 0 00000000 0
// Full-word write and read-back
1 000 DEADBEEF F 00000000 0
0 000 00000000 0 DEADBEEF 0
1 004 12345678 F 00000000 0
0 004 00000000 0 12345678 0
1 008 A5A5A5A5 F 00000000 0
0 008 00000000 0 A5A5A5A5 0
1 00C 0BADF00D F 00000000 0
0 00C 00000000 0 0BADF00D 0
// Partial strobes
1 000 11223344 5 00000000 0
0 000 00000000 0 DE22BE44 0
1 004 AABBCCDD A 00000000 0
0 004 00000000 0 AA34CC78 0
1 00C FFFFFFFF 0 00000000 0
0 00C 00000000 0 0BADF00D 0
// Unaligned and out of range
0 002 00000000 0 00000000 1
1 009 FFFFFFFF F 00000000 1
0 008 00000000 0 A5A5A5A5 0
0 040 00000000 0 00000000 1
1 044 CAFEF00D F 00000000 1
0 004 00000000 0 AA34CC78 0
1 3FC 12345678 F 00000000 1
0 03C 00000000 0 00000000 0
// Burst, mostly three wait states
1 01C 00000001 F 00000000 0
1 02C 00000002 F 00000000 0
1 03C 00000003 F 00000000 0
1 02C 00000004 F 00000000 0
0 01C 00000000 0 00000001 0
0 02C 00000000 0 00000004 0
0 03C 00000000 0 00000003 0
1 014 55AA55AA F 00000000 0
0 014 00000000 0 55AA55AA 0
0 018 00000000 0 00000000 0

//--- flist.f
+incdir+rtl
rtl/apb_bus_pkg.sv
rtl/apb_cmd_pkg.sv
rtl/apb_cmd_queue.sv
rtl/apb_requester.sv
rtl/apb_reg_target.sv
rtl/apb_sys_top.sv
bench/apb_sys_tb.sv

//--- Makefile
# Verilator flow for the APB subsystem, run from the project root
TOP := apb_sys_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert -f flist.f --top-module $(TOP)

# Pass only if the run prints the pass line
sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- bench/apb_sys_tb.sv
`timescale 1ns/1ps
// ------------------------------
// Reads bench/apb_tb_input.hex, so it runs from the project root
// Commands are spaced at least one cycle apart, cmd_full is checked mid-cycle
// ------------------------------
`include "apb_sys_consts.svh"

module apb_sys_tb;
	import apb_cmd_pkg::*;

	// Vector layout, six hex words per command
	localparam int NUM_VECS        = 38;
	localparam int VEC_FIELDS      = 6;
	localparam int F_OP            = 0;
	localparam int F_ADDR          = 1;
	localparam int F_WDATA         = 2;
	localparam int F_STRB          = 3;
	localparam int F_RDATA         = 4;
	localparam int F_ERR           = 5;
	// Back-pressure section, sent with no gaps
	localparam int BURST_FIRST     = 28;
	localparam int BURST_LAST      = 37;
	localparam int WATCHDOG_CYCLES = NUM_VECS * 12 + 100;

	logic     CLK;
	logic     reset;
	logic     cmd_valid;
	apb_cmd_t cmd;
	logic     cmd_full;
	logic     rsp_valid;
	apb_rsp_t rsp;

	logic [31:0] vec_words [NUM_VECS*VEC_FIELDS];
	int          seed;
	int          errors;
	int          rsp_count;
	// Commands taken by the queue so far
	int          sent_count;
	logic        full_seen;

	apb_sys_top u_dut (
		.CLK       (CLK),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_full  (cmd_full),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	// 4 ns clock
	always #2 CLK = ~CLK;

	function automatic logic [31:0] vec_field(input int idx, input int f);
		return vec_words[idx*VEC_FIELDS + f];
	endfunction

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic send_cmd(input int idx);
		int          gap;
		logic [31:0] addr_word;
		logic [31:0] strb_word;
		apb_cmd_t    c;
		gap = $unsigned($random(seed)) % 4;
		if (idx >= BURST_FIRST && idx <= BURST_LAST)
			gap = 0;
		addr_word = vec_field(idx, F_ADDR);
		strb_word = vec_field(idx, F_STRB);
		c.op      = (vec_field(idx, F_OP) != 0) ? CMD_WRITE : CMD_READ;
		c.addr    = addr_word[`APB_ADDR_BITS-1:0];
		c.wdata   = vec_field(idx, F_WDATA);
		c.strb    = strb_word[`APB_STRB_BITS-1:0];
		// Tag wraps every 16 commands
		c.tag     = TAG_BITS'(idx % 16);
		repeat (gap) @(posedge CLK);
		// Full is settled by mid-cycle, including the previous push
		@(negedge CLK);
		while (cmd_full)
			@(negedge CLK);
		@(posedge CLK);
		cmd_valid <= 1'b1;
		cmd       <= c;
		@(posedge CLK);
		cmd_valid <= 1'b0;
		// The queue took the command on this edge
		sent_count++;
	endtask

	// ------------------------------
	// Response checks
	// ------------------------------
	task automatic check_rsp;
		logic [TAG_BITS-1:0] exp_tag;
		cmd_op_t             exp_op;
		logic [31:0]         exp_rdata;
		logic                exp_err;
		if (rsp_count >= NUM_VECS) begin
			errors++;
			$display("unexpected response after the last command, tag %h", rsp.tag);
		end else begin
			exp_tag   = TAG_BITS'(rsp_count % 16);
			exp_op    = (vec_field(rsp_count, F_OP) != 0) ? CMD_WRITE : CMD_READ;
			exp_rdata = vec_field(rsp_count, F_RDATA);
			exp_err   = (vec_field(rsp_count, F_ERR) != 0);
			assert (rsp.tag == exp_tag) else begin
				errors++;
				$display("error rsp.tag vector %0d: got %h expected %h",
					rsp_count, rsp.tag, exp_tag);
			end
			assert (rsp.op == exp_op) else begin
				errors++;
				$display("error rsp.op vector %0d: got %h expected %h",
					rsp_count, rsp.op, exp_op);
			end
			assert (rsp.rdata == exp_rdata) else begin
				errors++;
				$display("error rsp.rdata vector %0d: got %h expected %h",
					rsp_count, rsp.rdata, exp_rdata);
			end
			assert (rsp.err == exp_err) else begin
				errors++;
				$display("error rsp.err vector %0d: got %h expected %h",
					rsp_count, rsp.err, exp_err);
			end
		end
		rsp_count++;
	endtask

	// Empty queue and no response while reset is held
	task automatic check_reset_state;
		assert (cmd_full == 1'b0) else begin
			errors++;
			$display("error cmd_full in reset: got %h expected %h", cmd_full, 1'b0);
		end
		assert (rsp_valid == 1'b0) else begin
			errors++;
			$display("error rsp_valid in reset: got %h expected %h", rsp_valid, 1'b0);
		end
	endtask

	// Full needs a whole queue of commands that have not been answered yet
	task automatic check_full;
		int outstanding;
		outstanding = sent_count - rsp_count;
		if (cmd_full) begin
			full_seen = 1'b1;
			assert (outstanding >= `CMD_QUEUE_DEPTH) else begin
				errors++;
				$display("error cmd_full: got %h expected %h, outstanding %h",
					cmd_full, 1'b0, outstanding);
			end
		end
	endtask

	// Strobe is one full cycle wide, so the falling edge sees it once
	always @(negedge CLK) begin
		if (reset) begin
			check_reset_state();
		end else begin
			if (rsp_valid)
				check_rsp();
			check_full();
		end
	end

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		CLK        = 1'b0;
		reset      = 1'b1;
		cmd_valid  = 1'b0;
		cmd        = '0;
		seed       = 52;
		errors     = 0;
		rsp_count  = 0;
		sent_count = 0;
		full_seen  = 1'b0;
		$readmemh("bench/apb_tb_input.hex", vec_words);
		repeat (10) @(posedge CLK);
		reset <= 1'b0;
		for (int i = 0; i < NUM_VECS; i++)
			send_cmd(i);
		// Quiet spell afterwards catches duplicate responses
		wait (rsp_count >= NUM_VECS);
		repeat (20) @(posedge CLK);
		// The zero-gap burst outruns the requester
		assert (full_seen) else begin
			errors++;
			$display("the queue never reported full during the command burst");
		end
		$display("checks failed: %0d, responses: %0d of %0d", errors, rsp_count, NUM_VECS);
		if (errors == 0 && rsp_count == NUM_VECS)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Bound scales with the vector count
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("timeout: only %0d of %0d responses arrived, checks failed: %0d",
			rsp_count, NUM_VECS, errors);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- rtl/apb_sys_top.sv
`timescale 1ns/1ps
// ------------------------------
// Queue, requester and one register target
// Source must not strobe cmd_valid while cmd_full is high
// ------------------------------

module apb_sys_top (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  cmd_valid,
	input  apb_cmd_pkg::apb_cmd_t cmd,
	output logic                  cmd_full,
	output logic                  rsp_valid,
	output apb_cmd_pkg::apb_rsp_t rsp
);
	import apb_cmd_pkg::*;
	import apb_bus_pkg::*;

	// Queue to requester
	apb_cmd_t q_head;
	logic     q_empty;
	logic     q_pop;

	// APB between requester and target
	apb_req_t bus_req;
	apb_rep_t bus_rep;

	apb_cmd_queue u_queue (
		.CLK      (CLK),
		.reset    (reset),
		.push     (cmd_valid),
		.push_cmd (cmd),
		.pop      (q_pop),
		.head     (q_head),
		.empty    (q_empty),
		.full     (cmd_full)
	);

	apb_requester u_requester (
		.CLK       (CLK),
		.reset     (reset),
		.q_empty   (q_empty),
		.q_head    (q_head),
		.q_pop     (q_pop),
		.bus_req   (bus_req),
		.bus_rep   (bus_rep),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	apb_reg_target u_target (
		.CLK     (CLK),
		.reset   (reset),
		.bus_req (bus_req),
		.bus_rep (bus_rep)
	);

endmodule

//--- rtl/apb_reg_target.sv
`timescale 1ns/1ps
// ------------------------------
// APB register file, wait states = PADDR[3:2]
// Unaligned or out-of-range access gives PSLVERR, no write, zero read data
// ------------------------------
`include "apb_sys_consts.svh"

module apb_reg_target (
	input  logic                  CLK,
	input  logic                  reset,
	input  apb_bus_pkg::apb_req_t bus_req,
	output apb_bus_pkg::apb_rep_t bus_rep
);
	localparam int IDX_BITS  = $clog2(`REG_WORDS);
	localparam int WAIT_BITS = $clog2(`APB_WAIT_MAX + 1);
	localparam int TOP_ADDR  = `REG_WORDS * 4;

	logic [`APB_DATA_BITS-1:0] regs [`REG_WORDS];
	logic [WAIT_BITS-1:0]      wait_cnt;
	logic [WAIT_BITS-1:0]      wait_need;
	logic [IDX_BITS-1:0]       idx;
	logic                      access;
	logic                      done;
	logic                      addr_err;

	// ------------------------------
	// Decode
	// ------------------------------
	assign access    = bus_req.sel && bus_req.enable;
	assign wait_need = WAIT_BITS'(bus_req.addr[3:2]);
	assign idx       = bus_req.addr[IDX_BITS+1:2];
	// Word aligned and inside the register map
	assign addr_err  = (bus_req.addr[1:0] != 2'b00) ||
		(bus_req.addr >= `APB_ADDR_BITS'(TOP_ADDR));
	// Ready once the wait count reaches the address-selected value
	assign done      = access && (wait_cnt == wait_need);

	// Reply is combinational from the count and the request
	always_comb begin
		bus_rep.ready  = done;
		bus_rep.slverr = done && addr_err;
		bus_rep.rdata  = '0;
		if (done && !bus_req.write && !addr_err)
			bus_rep.rdata = regs[idx];
	end

	// Wait counter, restarts for every access
	always_ff @(posedge CLK) begin
		if (reset)
			wait_cnt <= '0;
		else if (access && !done)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

	// ------------------------------
	// Register file
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `REG_WORDS; i++)
				regs[i] <= '0;
		end else if (done && bus_req.write && !addr_err) begin
			// Byte lanes follow PSTRB
			for (int b = 0; b < `APB_STRB_BITS; b++) begin
				if (bus_req.strb[b])
					regs[idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
			end
		end
	end

	// Every access ends within APB_WAIT_MAX extra cycles
	a_bounded_wait: assert property (@(posedge CLK) disable iff (reset)
		(access && wait_cnt == '0) |-> ##[0:`APB_WAIT_MAX] done);
	// Requester keeps the access phase up until ready
	a_access_held: assert property (@(posedge CLK) disable iff (reset)
		(access && !done) |=> access);

endmodule

//--- rtl/apb_requester.sv
`timescale 1ns/1ps
// ------------------------------
// APB requester, one transfer at a time
// Pops only from idle, so one idle cycle separates transfers
// ------------------------------

module apb_requester (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  q_empty,
	input  apb_cmd_pkg::apb_cmd_t q_head,
	output logic                  q_pop,
	output apb_bus_pkg::apb_req_t bus_req,
	input  apb_bus_pkg::apb_rep_t bus_rep,
	output logic                  rsp_valid,
	output apb_cmd_pkg::apb_rsp_t rsp
);
	import apb_cmd_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_ACCESS
	} state_t;

	state_t   state;
	logic     sel_q;
	logic     enable_q;
	// Command under transfer, source of the registered bus fields
	apb_cmd_t cmd_q;
	logic     done;

	// Take the head as soon as the bus is free
	assign q_pop = (state == ST_IDLE) && !q_empty;
	// Last access cycle
	assign done  = (state == ST_ACCESS) && bus_rep.ready;

	// Bus outputs all come from flops
	assign bus_req = '{
		sel:    sel_q,
		enable: enable_q,
		write:  (cmd_q.op == CMD_WRITE),
		addr:   cmd_q.addr,
		wdata:  cmd_q.wdata,
		strb:   cmd_q.strb
	};

	// ------------------------------
	// Phase FSM
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			state     <= ST_IDLE;
			sel_q     <= 1'b0;
			enable_q  <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			// Response is a single-cycle strobe
			rsp_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (q_pop) begin
						state <= ST_SETUP;
						sel_q <= 1'b1;
					end
				end
				// Setup is always exactly one cycle
				ST_SETUP: begin
					state    <= ST_ACCESS;
					enable_q <= 1'b1;
				end
				// Hold access until the target is ready
				ST_ACCESS: begin
					if (done) begin
						state     <= ST_IDLE;
						sel_q     <= 1'b0;
						enable_q  <= 1'b0;
						rsp_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Command latch and result capture
	always_ff @(posedge CLK) begin
		if (q_pop)
			cmd_q <= q_head;
		if (done)
			rsp <= '{tag: cmd_q.tag, op: cmd_q.op, rdata: bus_rep.rdata, err: bus_rep.slverr};
	end

	// Target sees a steady request while it inserts wait states
	a_req_stable: assert property (@(posedge CLK) disable iff (reset)
		(bus_req.sel && bus_req.enable && !bus_rep.ready) |=> $stable(bus_req));
	// Access phase only inside a selected transfer
	a_enable_sel: assert property (@(posedge CLK) disable iff (reset)
		bus_req.enable |-> bus_req.sel);

endmodule

//--- rtl/apb_cmd_queue.sv
`timescale 1ns/1ps
// ------------------------------
// Command FIFO, push dropped while full
// Head is valid only while empty is low
// ------------------------------
`include "apb_sys_consts.svh"

module apb_cmd_queue (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  push,
	input  apb_cmd_pkg::apb_cmd_t push_cmd,
	input  logic                  pop,
	output apb_cmd_pkg::apb_cmd_t head,
	output logic                  empty,
	output logic                  full
);
	import apb_cmd_pkg::*;

	localparam int DEPTH    = `CMD_QUEUE_DEPTH;
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	// Storage and pointers
	apb_cmd_t            mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_push;
	logic                do_pop;

	// Pointer step with wrap, depth need not be a power of two
	function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
		if (p == PTR_BITS'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == CNT_BITS'(DEPTH));
	assign head    = mem[rd_ptr];

	// ------------------------------
	// Control state
	// ------------------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			// Simultaneous push and pop leaves the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Payload, written at the tail
	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= push_cmd;
	end

	// Source must watch cmd_full
	a_no_push_full: assert property (@(posedge CLK) disable iff (reset) !(push && full));
	// Requester pops only what is there
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (reset) !(pop && empty));

endmodule

//--- rtl/apb_cmd_pkg.sv
// ------------------------------
// Command and response records
// Tag is echoed, never interpreted
// ------------------------------
`include "apb_sys_consts.svh"

package apb_cmd_pkg;

	// Tag width, 16 commands in flight can be told apart
	localparam int TAG_BITS = 4;

	typedef enum logic {
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_op_t;

	// One queued transfer
	typedef struct packed {
		cmd_op_t                     op;
		logic [`APB_ADDR_BITS-1:0]   addr;
		logic [`APB_DATA_BITS-1:0]   wdata;
		logic [`APB_STRB_BITS-1:0]   strb;
		logic [TAG_BITS-1:0]         tag;
	} apb_cmd_t;

	// One result, rdata is zero for writes and failed reads
	typedef struct packed {
		logic [TAG_BITS-1:0]         tag;
		cmd_op_t                     op;
		logic [`APB_DATA_BITS-1:0]   rdata;
		logic                        err;
	} apb_rsp_t;

endpackage

//--- rtl/apb_bus_pkg.sv
// ------------------------------
// APB bus signals as two structs
// No PPROT, single target only
// ------------------------------
`include "apb_sys_consts.svh"

package apb_bus_pkg;

	// Requester outputs
	// Everything but sel and enable holds from setup to the end of access
	typedef struct packed {
		logic                        sel;
		logic                        enable;
		logic                        write;
		logic [`APB_ADDR_BITS-1:0]   addr;
		logic [`APB_DATA_BITS-1:0]   wdata;
		logic [`APB_STRB_BITS-1:0]   strb;
	} apb_req_t;

	// Target outputs
	// rdata and slverr only mean something while ready is high
	typedef struct packed {
		logic [`APB_DATA_BITS-1:0]   rdata;
		logic                        ready;
		logic                        slverr;
	} apb_rep_t;

endpackage

//--- rtl/apb_sys_consts.svh
// ------------------------------
// Sizes of the APB subsystem
// Register map must fit below 2**APB_ADDR_BITS, wait states fit in PADDR[3:2]
// ------------------------------
`ifndef APB_SYS_CONSTS_SVH
`define APB_SYS_CONSTS_SVH

// Bus widths
`define APB_ADDR_BITS 10
`define APB_DATA_BITS 32

// One strobe bit per data byte
`define APB_STRB_BITS (`APB_DATA_BITS / 8)

// Command queue entries
`define CMD_QUEUE_DEPTH 4

// 32-bit registers in the target, byte addresses 0 to 4*REG_WORDS-1
`define REG_WORDS 16

// Largest wait state count the target inserts
`define APB_WAIT_MAX 3

`endif
